//--- hw/pipe_pkg.sv
/*
 * Pipeline sizes, opcode encoding, instruction word and retire record
 */
package pipe_pkg;

    //////////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////////

    localparam int PROG_DEPTH  = 32;
    localparam int PC_W        = $clog2(PROG_DEPTH);
    localparam int ID_W        = 8;
    localparam int CYC_W       = 16;
    // No more than five ids are in flight, so the low id bits are unique
    localparam int TRACE_DEPTH = 8;
    localparam int TRACE_IDX_W = $clog2(TRACE_DEPTH);
    localparam int DATA_W      = 8;
    localparam int NUM_REGS    = 4;
    localparam int REG_W       = $clog2(NUM_REGS);

    // Stage positions in the trace tap vectors
    localparam int NUM_STAGES  = 5;
    localparam int ST_F        = 0;
    localparam int ST_D        = 1;
    localparam int ST_E        = 2;
    localparam int ST_M        = 3;
    localparam int ST_W        = 4;

    //////////////////////////////////////////////////////////////////////////
    // Instruction and retire record
    //////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_LI  = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2,
        OP_BNZ = 2'd3
    } opcode_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        logic [REG_W-1:0]  rt;
        logic [DATA_W-1:0] imm;
    } instr_t;

    typedef struct packed {
        logic [ID_W-1:0]  id;
        logic [PC_W-1:0]  pc;
        logic             flushed;
        logic [CYC_W-1:0] fetch_cyc;
        logic [CYC_W-1:0] decode_cyc;
        logic [CYC_W-1:0] execute_cyc;
        logic [CYC_W-1:0] memory_cyc;
        logic [CYC_W-1:0] wb_cyc;
    } retire_t;

endpackage

//--- hw/stage_if.sv
/*
 * Instruction slot from fetch into decode
 */
`timescale 1ns/1ps

interface stage_if;
    import pipe_pkg::*;

    // Slot is taken on a cycle with valid high and stall low
    logic            valid;
    logic [ID_W-1:0] id;
    logic [PC_W-1:0] pc;
    instr_t          instr;

    modport src (
        output valid, id, pc, instr
    );

    modport dst (
        input valid, id, pc, instr
    );

endinterface

//--- hw/trace_tap_if.sv
/*
 * Per-stage occupancy, ids and kill flags observed by the trace unit
 */
`timescale 1ns/1ps

interface trace_tap_if;
    import pipe_pkg::*;

    // Entry ST_F comes from fetch, the other four from the back pipe
    logic [NUM_STAGES-1:0]           stage_valid;
    logic [NUM_STAGES-1:0][ID_W-1:0] stage_id;
    logic [NUM_STAGES-1:0]           stage_killed;
    // pc of the slot sitting in fetch
    logic [PC_W-1:0]                 fetch_pc;
    logic                            stall;
    logic                            flush;

    modport pipe (
        output stage_valid, stage_id, stage_killed, fetch_pc, stall, flush
    );

    modport trace (
        input stage_valid, stage_id, stage_killed, fetch_pc, stall, flush
    );

endinterface

//--- hw/fetch_stage.sv
/*
 * Program memory with load port, program counter, id counter and run control
 */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      prog_we,
    input  logic [pipe_pkg::PC_W-1:0] prog_addr,
    input  pipe_pkg::instr_t          prog_data,
    input  logic                      stall,
    input  logic                      flush,
    input  logic [pipe_pkg::PC_W-1:0] redirect_pc,
    output logic                      fetch_done,
    output logic                      busy,
    stage_if.src                      out,
    trace_tap_if.pipe                 tap
);
    import pipe_pkg::*;

    instr_t          prog_mem [PROG_DEPTH];
    logic [PC_W-1:0] pc;
    logic [ID_W-1:0] next_id;
    logic            take;
    logic            drained;

    // Loads only land while the core is idle
    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    assign out.valid = busy && !fetch_done;
    assign out.id    = next_id;
    assign out.pc    = pc;
    assign out.instr = prog_mem[pc];
    assign take      = out.valid && !stall;
    assign drained   = ~|tap.stage_valid[NUM_STAGES-1:ST_D];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            next_id    <= '0;
            busy       <= 1'b0;
            fetch_done <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                pc         <= '0;
                busy       <= 1'b1;
                fetch_done <= 1'b0;
            end
        end else begin
            // Killed slots still consume an id
            if (take) begin
                next_id <= next_id + 1'b1;
            end
            if (flush) begin
                pc         <= redirect_pc;
                fetch_done <= 1'b0;
            end else if (take) begin
                pc <= pc + 1'b1;
                if (pc == PC_W'(PROG_DEPTH - 1)) begin
                    fetch_done <= 1'b1;
                end
            end else if (fetch_done && drained) begin
                busy <= 1'b0;
            end
        end
    end

    assign tap.stage_valid[ST_F]  = out.valid;
    assign tap.stage_id[ST_F]     = next_id;
    assign tap.stage_killed[ST_F] = out.valid && flush;
    assign tap.fetch_pc           = pc;
    assign tap.stall              = stall;
    assign tap.flush              = flush;

endmodule

//--- hw/hazard_unit.sv
/*
 * Read-after-write stall detection and branch flush with redirect
 */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_pkg::instr_t           dec_instr,
    input  logic                       dec_valid,
    input  logic [pipe_pkg::REG_W-1:0] ex_rd,
    input  logic [pipe_pkg::REG_W-1:0] mem_rd,
    input  logic                       ex_writes,
    input  logic                       mem_writes,
    input  logic                       branch_taken,
    input  logic [pipe_pkg::PC_W-1:0]  branch_target,
    output logic                       stall,
    output logic                       flush,
    output logic [pipe_pkg::PC_W-1:0]  redirect_pc
);
    import pipe_pkg::*;

    logic reads_rs;
    logic reads_rt;
    logic ex_hit;
    logic mem_hit;
    logic flush_q;

    // LI reads nothing, BNZ tests rs only
    assign reads_rs = dec_instr.opcode != OP_LI;
    assign reads_rt = (dec_instr.opcode == OP_ADD) || (dec_instr.opcode == OP_SUB);

    assign ex_hit  = ex_writes && ((reads_rs && dec_instr.rs == ex_rd) ||
                                   (reads_rt && dec_instr.rt == ex_rd));
    assign mem_hit = mem_writes && ((reads_rs && dec_instr.rs == mem_rd) ||
                                    (reads_rt && dec_instr.rt == mem_rd));

    // A flush lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush;
        end
    end

    assign flush       = branch_taken && !flush_q;
    assign stall       = dec_valid && (ex_hit || mem_hit) && !flush;
    assign redirect_pc = branch_target;

endmodule

//--- hw/exec_pipe.sv
/*
 * Decode, execute, memory and write-back registers, register file, branches
 */
`timescale 1ns/1ps

module exec_pipe (
    input  logic                        clk,
    input  logic                        rst,
    stage_if.dst                        in,
    input  logic                        stall,
    input  logic                        flush,
    output pipe_pkg::instr_t            dec_instr,
    output logic                        dec_valid,
    output logic [pipe_pkg::REG_W-1:0]  ex_rd,
    output logic [pipe_pkg::REG_W-1:0]  mem_rd,
    output logic                        ex_writes,
    output logic                        mem_writes,
    output logic                        branch_taken,
    output logic [pipe_pkg::PC_W-1:0]   branch_target,
    output logic                        wb_we,
    output logic [pipe_pkg::REG_W-1:0]  wb_rd,
    output logic [pipe_pkg::DATA_W-1:0] wb_data,
    trace_tap_if.pipe                   tap
);
    import pipe_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              d_valid, d_killed, e_valid, e_killed;
    logic              m_valid, m_killed, m_we, w_valid, w_killed;
    logic [ID_W-1:0]   d_id, e_id, m_id, w_id;
    logic [PC_W-1:0]   d_pc, e_pc;
    instr_t            d_instr, e_instr;
    logic [DATA_W-1:0] e_a, e_b, e_res, m_data;
    logic [DATA_W:0]   e_sum;
    logic [REG_W-1:0]  m_rd;
    logic              e_live;

    // Register read in decode sees the write-back value of the same cycle
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_W-1:0] idx);
        read_reg = (wb_we && wb_rd == idx) ? wb_data : regs[idx];
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Stage control, bubble into execute on stall
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid  <= 1'b0;
            d_killed <= 1'b0;
            e_valid  <= 1'b0;
            e_killed <= 1'b0;
            m_valid  <= 1'b0;
            m_killed <= 1'b0;
            m_we     <= 1'b0;
            w_valid  <= 1'b0;
            w_killed <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            if (!stall) begin
                d_valid  <= in.valid;
                d_killed <= flush;
            end
            e_valid  <= d_valid && !stall;
            e_killed <= d_killed || flush;
            m_valid  <= e_valid;
            m_killed <= e_killed;
            m_we     <= ex_writes;
            w_valid  <= m_valid;
            w_killed <= m_killed;
            wb_we    <= m_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_id    <= in.id;
            d_pc    <= in.pc;
            d_instr <= in.instr;
        end
        e_id    <= d_id;
        e_pc    <= d_pc;
        e_instr <= d_instr;
        e_a     <= read_reg(d_instr.rs);
        e_b     <= read_reg(d_instr.rt);
        m_id    <= e_id;
        m_rd    <= e_instr.rd;
        m_data  <= e_res;
        w_id    <= m_id;
        wb_rd   <= m_rd;
        wb_data <= m_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (e_instr.opcode)
            OP_LI:   e_res = e_instr.imm;
            OP_ADD:  e_res = e_a + e_b;
            OP_SUB:  e_res = e_a - e_b;
            default: e_res = '0;
        endcase
    end

    // Target past the last word falls through
    assign e_sum         = (DATA_W+1)'(e_pc) + (DATA_W+1)'(e_instr.imm);
    assign e_live        = e_valid && !e_killed;
    assign branch_taken  = e_live && e_instr.opcode == OP_BNZ && e_a != '0 &&
                           e_sum < (DATA_W+1)'(PROG_DEPTH);
    assign branch_target = e_sum[PC_W-1:0];

    assign dec_instr  = d_instr;
    assign dec_valid  = d_valid && !d_killed;
    assign ex_rd      = e_instr.rd;
    assign ex_writes  = e_live && e_instr.opcode != OP_BNZ;
    assign mem_rd     = m_rd;
    assign mem_writes = m_we;

    assign tap.stage_valid[ST_W:ST_D]  = {w_valid, m_valid, e_valid, d_valid};
    assign tap.stage_id[ST_W:ST_D]     = {w_id, m_id, e_id, d_id};
    assign tap.stage_killed[ST_W:ST_D] = {w_killed, m_killed, e_killed, d_killed};

endmodule

//--- hw/trace_unit.sv
/*
 * Cycle counter, per-id stamp table and registered retire records
 */
`timescale 1ns/1ps

module trace_unit (
    input  logic              clk,
    input  logic              rst,
    trace_tap_if.trace        tap,
    output pipe_pkg::retire_t retire,
    output logic              retire_valid
);
    import pipe_pkg::*;

    logic [CYC_W-1:0]                       cycle;
    logic [CYC_W-1:0]                       fetch_tbl [TRACE_DEPTH];
    logic [CYC_W-1:0]                       decode_tbl [TRACE_DEPTH];
    logic [CYC_W-1:0]                       exec_tbl [TRACE_DEPTH];
    logic [CYC_W-1:0]                       mem_tbl [TRACE_DEPTH];
    logic [PC_W-1:0]                        pc_tbl [TRACE_DEPTH];
    logic [NUM_STAGES-1:0][TRACE_IDX_W-1:0] slot;
    logic                                   front_adv;

    // Fetch and decode hold under stall, a flush always moves them on
    assign front_adv = !tap.stall || tap.flush;

    always_comb begin
        for (int s = 0; s < NUM_STAGES; s++) begin
            slot[s] = tap.stage_id[s][TRACE_IDX_W-1:0];
        end
    end

    // Zero on the first cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stamp on the last cycle an id sits in each stage
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tap.stage_valid[ST_F] && front_adv) begin
            fetch_tbl[slot[ST_F]] <= cycle;
            pc_tbl[slot[ST_F]]    <= tap.fetch_pc;
        end
        if (tap.stage_valid[ST_D] && front_adv) begin
            decode_tbl[slot[ST_D]] <= cycle;
        end
        if (tap.stage_valid[ST_E]) begin
            exec_tbl[slot[ST_E]] <= cycle;
        end
        if (tap.stage_valid[ST_M]) begin
            mem_tbl[slot[ST_M]] <= cycle;
        end
    end

    // Write-back always advances, so the record closes here
    always_ff @(posedge clk) begin
        if (tap.stage_valid[ST_W]) begin
            retire.id          <= tap.stage_id[ST_W];
            retire.pc          <= pc_tbl[slot[ST_W]];
            retire.flushed     <= tap.stage_killed[ST_W];
            retire.fetch_cyc   <= fetch_tbl[slot[ST_W]];
            retire.decode_cyc  <= decode_tbl[slot[ST_W]];
            retire.execute_cyc <= exec_tbl[slot[ST_W]];
            retire.memory_cyc  <= mem_tbl[slot[ST_W]];
            retire.wb_cyc      <= cycle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= tap.stage_valid[ST_W];
        end
    end

endmodule

//--- hw/pipe_trace_top.sv
/*
 * Five-stage pipeline with instruction trace, plain ports at the boundary
 */
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                prog_we,
    input  logic [pipe_pkg::PC_W-1:0]           prog_addr,
    input  logic [$bits(pipe_pkg::instr_t)-1:0] prog_data,
    input  logic                                start,
    output logic                                busy,
    output logic                                retire_valid,
    output logic [pipe_pkg::ID_W-1:0]           retire_id,
    output logic [pipe_pkg::PC_W-1:0]           retire_pc,
    output logic                                retire_flushed,
    output logic [pipe_pkg::CYC_W-1:0]          fetch_cyc,
    output logic [pipe_pkg::CYC_W-1:0]          decode_cyc,
    output logic [pipe_pkg::CYC_W-1:0]          execute_cyc,
    output logic [pipe_pkg::CYC_W-1:0]          memory_cyc,
    output logic [pipe_pkg::CYC_W-1:0]          wb_cyc,
    output logic                                wb_we,
    output logic [pipe_pkg::REG_W-1:0]          wb_rd,
    output logic [pipe_pkg::DATA_W-1:0]         wb_data
);
    import pipe_pkg::*;

    stage_if     slot_if ();
    trace_tap_if tap_if ();

    instr_t           dec_instr;
    logic             dec_valid, ex_writes, mem_writes;
    logic [REG_W-1:0] ex_rd, mem_rd;
    logic             branch_taken, stall, flush;
    logic [PC_W-1:0]  branch_target, redirect_pc;
    retire_t          retire;

    fetch_stage i_fetch_stage (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .stall       (stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch_done  (),
        .busy        (busy),
        .out         (slot_if),
        .tap         (tap_if)
    );

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .rst           (rst),
        .dec_instr     (dec_instr),
        .dec_valid     (dec_valid),
        .ex_rd         (ex_rd),
        .mem_rd        (mem_rd),
        .ex_writes     (ex_writes),
        .mem_writes    (mem_writes),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .stall         (stall),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    exec_pipe i_exec_pipe (
        .clk           (clk),
        .rst           (rst),
        .in            (slot_if),
        .stall         (stall),
        .flush         (flush),
        .dec_instr     (dec_instr),
        .dec_valid     (dec_valid),
        .ex_rd         (ex_rd),
        .mem_rd        (mem_rd),
        .ex_writes     (ex_writes),
        .mem_writes    (mem_writes),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .tap           (tap_if)
    );

    trace_unit i_trace_unit (
        .clk          (clk),
        .rst          (rst),
        .tap          (tap_if),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    assign retire_id      = retire.id;
    assign retire_pc      = retire.pc;
    assign retire_flushed = retire.flushed;
    assign fetch_cyc      = retire.fetch_cyc;
    assign decode_cyc     = retire.decode_cyc;
    assign execute_cyc    = retire.execute_cyc;
    assign memory_cyc     = retire.memory_cyc;
    assign wb_cyc         = retire.wb_cyc;

endmodule

//--- dv/pipe_trace_model.svh
/*
 * Random program generator and architectural model of the pipeline,
 * expected retire records and register writes
 */

// Execute position and writer of the two slots before the current one
int               slot_pos;
bit               wr1;
bit               wr2;
logic [REG_W-1:0] rd1;
logic [REG_W-1:0] rd2;
int               pos1;
int               pos2;

// LI reads nothing, BNZ tests rs only
function automatic bit reads_reg(input instr_t ins, input logic [REG_W-1:0] r);
    reads_reg = (ins.opcode != OP_LI && ins.rs == r) ||
                ((ins.opcode == OP_ADD || ins.opcode == OP_SUB) && ins.rt == r);
endfunction

task automatic gen_program(input bit with_branches);
    logic [31:0] raw;
    int          i;
    for (i = 0; i < PROG_DEPTH; i++) begin
        raw = $random(seed);
        prog[PC_W'(i)] = raw[15:0];
        if (!with_branches && prog[PC_W'(i)].opcode == OP_BNZ) begin
            prog[PC_W'(i)].opcode = OP_ADD;
        end
        // Forward offset of 1 to 4
        if (prog[PC_W'(i)].opcode == OP_BNZ) begin
            prog[PC_W'(i)].imm = 8'd1 + 8'(raw[17:16]);
        end
    end
endtask

task automatic record_write(input logic [REG_W-1:0] rd, input logic [DATA_W-1:0] data);
    exp_wr_t wr;
    wr.rd = int'(rd);
    wr.data = int'(data);
    exp_wrs.push_back(wr);
    model_regs[rd] = data;
endtask

task automatic push_slot(input int pc, input bit flushed);
    instr_t   ins;
    exp_rec_t rec;
    int       pos;
    ins = prog[PC_W'(pc)];
    pos = slot_pos + 1;
    // A reader leaves decode once its producer sits in write-back
    if (!flushed && wr1 && reads_reg(ins, rd1) && pos1 + 3 > pos) begin
        pos = pos1 + 3;
    end
    if (!flushed && wr2 && reads_reg(ins, rd2) && pos2 + 3 > pos) begin
        pos = pos2 + 3;
    end
    rec.pc = pc;
    rec.flushed = flushed;
    rec.gap = pos - slot_pos;
    rec.pos = pos;
    exp_recs.push_back(rec);
    wr2 = wr1;
    rd2 = rd1;
    pos2 = pos1;
    wr1 = !flushed && ins.opcode != OP_BNZ;
    rd1 = ins.rd;
    pos1 = pos;
    slot_pos = pos;
endtask

task automatic run_model();
    instr_t ins;
    int     pc;
    int     next_pc;
    int     k;
    slot_pos = -1;
    wr1 = 1'b0;
    wr2 = 1'b0;
    pc = 0;
    while (pc < PROG_DEPTH) begin
        ins = prog[PC_W'(pc)];
        push_slot(pc, 1'b0);
        next_pc = pc + 1;
        case (ins.opcode)
            OP_LI:  record_write(ins.rd, ins.imm);
            OP_ADD: record_write(ins.rd, model_regs[ins.rs] + model_regs[ins.rt]);
            OP_SUB: record_write(ins.rd, model_regs[ins.rs] - model_regs[ins.rt]);
            default: begin
                // Targets past the last word fall through
                if (model_regs[ins.rs] != '0 && pc + int'(ins.imm) < PROG_DEPTH) begin
                    for (k = 1; k <= 2; k++) begin
                        if (pc + k < PROG_DEPTH) begin
                            push_slot(pc + k, 1'b1);
                        end else begin
                            // Fetch already passed the end and execute sees an empty slot
                            slot_pos = slot_pos + 1;
                        end
                    end
                    next_pc = pc + int'(ins.imm);
                end
            end
        endcase
        pc = next_pc;
    end
endtask

//--- dv/pipe_trace_tb.sv
/*
 * Testbench for the traced pipeline: random programs, model based
 * checks of register writes, retire records and stamps, watchdog
 */
`timescale 1ns/1ps

module pipe_trace_tb;
    import pipe_pkg::*;

    localparam int NUM_PROGS    = 20;
    // The first programs hold no branches
    localparam int NUM_STRAIGHT = 4;

    typedef struct {
        int pc;
        bit flushed;
        int gap;
        // Execute position within the run
        int pos;
    } exp_rec_t;

    typedef struct {
        int rd;
        int data;
    } exp_wr_t;

    logic                clk;
    logic                rst;
    logic                prog_we;
    logic [PC_W-1:0]     prog_addr;
    logic [15:0]         prog_data;
    logic                start;
    logic                busy;
    logic                retire_valid;
    logic [ID_W-1:0]     retire_id;
    logic [PC_W-1:0]     retire_pc;
    logic                retire_flushed;
    logic [CYC_W-1:0]    fetch_cyc;
    logic [CYC_W-1:0]    decode_cyc;
    logic [CYC_W-1:0]    execute_cyc;
    logic [CYC_W-1:0]    memory_cyc;
    logic [CYC_W-1:0]    wb_cyc;
    logic                wb_we;
    logic [REG_W-1:0]    wb_rd;
    logic [DATA_W-1:0]   wb_data;

    integer              seed = 32'h1906;
    int                  errors = 0;
    int                  checks = 0;
    instr_t              prog [PROG_DEPTH];
    logic [DATA_W-1:0]   model_regs [NUM_REGS] = '{default: '0};
    exp_rec_t            exp_recs [$];
    exp_wr_t             exp_wrs [$];
    logic [ID_W-1:0]     exp_id = '0;
    bit                  first_in_run = 1'b1;
    int                  last_wb = 0;
    int                  last_pos = 0;

    `include "pipe_trace_model.svh"

    pipe_trace_top i_pipe_trace_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////////

    task automatic compare(input int actual, input int expected, input string msg);
        checks++;
        if (actual != expected) begin
            $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, msg, actual,
                     expected);
            errors++;
        end
    endtask

    task automatic check_retire();
        exp_rec_t rec;
        int       dc;
        int       wc;
        if (exp_recs.size() == 0) begin
            $display("Retire record for pc %0d arrived at %0t with none expected",
                     retire_pc, $time);
            errors++;
        end else begin
            rec = exp_recs.pop_front();
            dc = int'(decode_cyc);
            wc = int'(wb_cyc);
            compare(int'(retire_pc), rec.pc, "retire pc");
            compare(int'(retire_flushed), int'(rec.flushed), "flushed flag");
            compare(int'(retire_id), int'(exp_id), "retire id");
            compare(int'(execute_cyc), dc + 1, "execute stamp");
            compare(int'(memory_cyc), int'(execute_cyc) + 1, "memory stamp");
            compare(wc, int'(memory_cyc) + 1, "write-back stamp");
            // Stalls stretch the time between fetch and decode
            compare(dc - int'(fetch_cyc), rec.gap, "decode minus fetch stamp");
            if (!first_in_run) begin
                compare(wc - last_wb, rec.pos - last_pos, "write-back stamp spacing");
            end
            first_in_run = 1'b0;
            last_wb = wc;
            last_pos = rec.pos;
            exp_id = exp_id + 8'd1;
        end
    endtask

    task automatic check_write();
        exp_wr_t wr;
        if (exp_wrs.size() == 0) begin
            $display("Register write to r%0d at %0t with none expected", wb_rd, $time);
            errors++;
        end else begin
            wr = exp_wrs.pop_front();
            compare(int'(wb_rd), wr.rd, "write-back register");
            compare(int'(wb_data), wr.data, "write-back data");
        end
    endtask

    always @(negedge clk) begin
        if (retire_valid) begin
            check_retire();
        end
        if (wb_we) begin
            check_write();
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////////

    task automatic load_program();
        int i;
        for (i = 0; i < PROG_DEPTH; i++) begin
            @(negedge clk);
            prog_we = 1'b1;
            prog_addr = PC_W'(i);
            prog_data = prog[PC_W'(i)];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic run_program();
        first_in_run = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare(int'(busy), 1, "busy after start");
        while (busy) begin
            @(negedge clk);
        end
        compare(exp_recs.size(), 0, "retire records still expected after busy fell");
        compare(exp_wrs.size(), 0, "register writes still expected after busy fell");
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        compare(int'(busy), 0, "busy after reset");
        compare(int'(retire_valid), 0, "retire_valid after reset");
        for (int p = 0; p < NUM_PROGS; p++) begin
            gen_program(p >= NUM_STRAIGHT);
            run_model();
            load_program();
            run_program();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Reset plus a generous budget per program for loading and running
    initial begin
        repeat (16 + NUM_PROGS * (PROG_DEPTH * 4 + 40)) @(posedge clk);
        $display("Timeout: the programs did not finish within the cycle budget");
        $display("tests failed");
        $finish;
    end

endmodule

//--- pipe_trace.f
hw/pipe_pkg.sv
hw/stage_if.sv
hw/trace_tap_if.sv
hw/fetch_stage.sv
hw/hazard_unit.sv
hw/exec_pipe.sv
hw/trace_unit.sv
hw/pipe_trace_top.sv
+incdir+dv
dv/pipe_trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module pipe_trace_tb -f pipe_trace.f -o pipe_trace_sim &&
./obj_dir/pipe_trace_sim | tee /dev/stderr | grep -x "all tests passed" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
